//--- verilog/dmb_config.svh
`ifndef DMB_CONFIG_SVH
`define DMB_CONFIG_SVH

// VME data and command fields
`define DMB_DATA_W 16
`define DMB_CMD_W 10

// Front-end boards on the CFEB JTAG chain
`define DMB_NUM_CFEB 5

// Device 1 commands
`define DMB_CMD_CFEB_SEL 8
`define DMB_CMD_CFEB_READ 9

// Free-running phase counter, 32 fastclk cycles per slow2 period
`define DMB_CLKCNT_W 5

// JTAG init window, bit 4 is the window and bit 5 ends it
`define DMB_INIT_TIMER_W 6

// VPROM release count, bit 7 ends the hold
`define DMB_VPROM_CNT_W 8

// Data-buffer OE delay, saturates at bit 7
`define DMB_OE_TIMER_W 8

`endif

//--- verilog/dmb_pkg.sv
`default_nettype none

`include "dmb_config.svh"

package dmb_pkg;

	// One VME data word
	typedef logic [`DMB_DATA_W-1:0] vme_data_t;

	// Command field from the VME decoder
	typedef logic [`DMB_CMD_W-1:0] vme_cmd_t;

	// One bit per CFEB, one-hot when a single board is selected
	typedef logic [`DMB_NUM_CFEB-1:0] cfeb_mask_t;

	// Phase counter value
	typedef logic [`DMB_CLKCNT_W-1:0] clk_cnt_t;

endpackage

`default_nettype wire

//--- verilog/clk_phase_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clk_phase_gen (
	input  logic fastclk,
	input  logic jtimer_clr,
	output logic mid_en_o,
	output logic neg_mid_en_o,
	output logic slow_en_o,
	output logic neg_slow_en_o,
	output logic slow2_en_o,
	output logic neg_slow2_en_o
);
	import dmb_pkg::*;

	clk_cnt_t clk_cnt;

	// Wraps every 32 cycles
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			clk_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Enables are registered one cycle after the count matches
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			mid_en_o       <= 1'b0;
			neg_mid_en_o   <= 1'b0;
			slow_en_o      <= 1'b0;
			neg_slow_en_o  <= 1'b0;
			slow2_en_o     <= 1'b0;
			neg_slow2_en_o <= 1'b0;
		end else begin
			// Every 4 counts, negative phase two counts later
			mid_en_o       <= (clk_cnt[1:0] == 2'd0);
			neg_mid_en_o   <= (clk_cnt[1:0] == 2'd2);
			// Every 16 counts
			slow_en_o      <= (clk_cnt[3:0] == 4'd0);
			neg_slow_en_o  <= (clk_cnt[3:0] == 4'd8);
			// Once per wrap
			slow2_en_o     <= (clk_cnt == clk_cnt_t'(0));
			neg_slow2_en_o <= (clk_cnt == clk_cnt_t'(16));
		end
	end

	// Slow2 phases sit half a period apart
	a_slow2_phases: assert property (@(posedge fastclk) disable iff (jtimer_clr)
		!(slow2_en_o && neg_slow2_en_o));

endmodule

`default_nettype wire

//--- verilog/jtag_init_seq.sv
`timescale 1ns/1ns
`default_nettype none

`include "dmb_config.svh"

module jtag_init_seq (
	input  logic fastclk,
	input  logic jtimer_clr,
	input  logic glb_rst_i,
	input  logic soft_rst_i,
	input  logic done_trg_i,
	input  logic slow2_en_i,
	output logic ctrl_rst_o,
	output logic init_jtags_o
);

	logic ctrl_rst_req;
	logic ctrl_rst_d;
	logic rst_release;
	logic strt_jinit;
	logic jinit_done;
	logic seq_clr;
	logic [`DMB_INIT_TIMER_W-1:0] jinit_timer;

	//////////////////////////////////////////////////////////////////////
	// Reset merge and release detect
	//////////////////////////////////////////////////////////////////////

	// Soft reset only counts once the FPGAs are configured
	assign ctrl_rst_req = glb_rst_i | (soft_rst_i & done_trg_i);

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			ctrl_rst_o <= 1'b0;
			ctrl_rst_d <= 1'b0;
		end else begin
			ctrl_rst_o <= ctrl_rst_req;
			ctrl_rst_d <= ctrl_rst_o;
		end
	end

	// Falling edge of the registered reset
	assign rst_release = ctrl_rst_d & ~ctrl_rst_o;

	//////////////////////////////////////////////////////////////////////
	// Init window timer
	//////////////////////////////////////////////////////////////////////

	// Request is used directly so the timer is idle when ctrl_rst_o rises
	assign seq_clr = ctrl_rst_req | jinit_done;

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			strt_jinit  <= 1'b0;
			jinit_timer <= '0;
		end else if (seq_clr) begin
			strt_jinit  <= 1'b0;
			jinit_timer <= '0;
		end else begin
			strt_jinit <= rst_release | strt_jinit;
			if (slow2_en_i && strt_jinit) begin
				jinit_timer <= jinit_timer + 1'b1;
			end
		end
	end

	// Timer past the window, sampled on the slow2 phase
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			jinit_done <= 1'b0;
		end else if (slow2_en_i) begin
			jinit_done <= jinit_timer[5];
		end
	end

	// High for counts 16 to 31
	assign init_jtags_o = jinit_timer[4];

	a_init_after_rst: assert property (@(posedge fastclk) disable iff (jtimer_clr)
		$rose(init_jtags_o) |-> !ctrl_rst_o);

endmodule

`default_nettype wire

//--- verilog/cfeb_sel_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "dmb_config.svh"

module cfeb_sel_regs (
	input  logic               fastclk,
	input  logic               jtimer_clr,
	input  logic               ctrl_rst_i,
	input  logic               strobe_i,
	input  logic               strbce_i,
	input  logic               write_b_i,
	input  logic               dev_cfeb_i,
	input  dmb_pkg::vme_cmd_t  command_i,
	input  dmb_pkg::vme_data_t indata_i,
	input  dmb_pkg::cfeb_mask_t cfeb_tdo_i,
	input  logic               tck_i,
	input  logic               tdi_i,
	input  logic               tms_i,
	output dmb_pkg::vme_data_t rdata_o,
	output logic               dtack_o,
	output dmb_pkg::cfeb_mask_t cfeb_tck_o,
	output logic               cfeb_tdi_o,
	output logic               cfeb_tms_o,
	output logic               cfeb_tdo_o
);
	import dmb_pkg::*;

	cfeb_mask_t cfeb_sel;
	logic       sel_cmd;
	logic       read_cmd;
	logic       dt_wrtsel;
	logic       dt_rdsel;
	logic       sel_onehot;

	assign sel_cmd  = dev_cfeb_i & (command_i == vme_cmd_t'(`DMB_CMD_CFEB_SEL));
	assign read_cmd = dev_cfeb_i & (command_i == vme_cmd_t'(`DMB_CMD_CFEB_READ));

	// Select mask
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			cfeb_sel <= '0;
		end else if (ctrl_rst_i) begin
			cfeb_sel <= '0;
		end else if (sel_cmd && strbce_i) begin
			cfeb_sel <= indata_i[`DMB_NUM_CFEB-1:0];
		end
	end

	// Acknowledge follows the strobe by one cycle
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			dt_wrtsel <= 1'b0;
			dt_rdsel  <= 1'b0;
		end else begin
			dt_wrtsel <= strobe_i & sel_cmd;
			dt_rdsel  <= strobe_i & read_cmd;
		end
	end

	assign dtack_o = dt_wrtsel | dt_rdsel;

	assign rdata_o = (write_b_i && read_cmd) ?
		{{(`DMB_DATA_W-`DMB_NUM_CFEB){1'b0}}, cfeb_sel} : '0;

	//////////////////////////////////////////////////////////////////////
	// JTAG routing
	//////////////////////////////////////////////////////////////////////

	assign cfeb_tck_o = {`DMB_NUM_CFEB{tck_i}} & cfeb_sel;
	assign cfeb_tdi_o = tdi_i;
	assign cfeb_tms_o = tms_i;

	// TDO only comes back from a single selected board
	assign sel_onehot = (cfeb_sel != '0) && ((cfeb_sel & (cfeb_sel - 1'b1)) == '0);
	assign cfeb_tdo_o = sel_onehot & (|(cfeb_sel & cfeb_tdo_i));

	a_tck_in_mask: assert property (@(posedge fastclk) disable iff (jtimer_clr)
		(cfeb_tck_o & ~cfeb_sel) == '0);

endmodule

`default_nettype wire

//--- verilog/vprom_en_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dmb_config.svh"

module vprom_en_ctrl (
	input  logic fastclk,
	input  logic jtimer_clr,
	input  logic ctrl_rst_i,
	input  logic dev_vprom_i,
	input  logic init_jtags_i,
	input  logic slow2_en_i,
	output logic vprom_en_o
);

	logic vprom_hld;
	logic cnt_msb_q;
	logic release_done;
	logic [`DMB_VPROM_CNT_W-1:0] release_cnt;

	// Drivers stay on while addressed, during init and for the hold time
	assign vprom_en_o = dev_vprom_i | init_jtags_i | vprom_hld;

	// Count expired and the device is no longer addressed
	assign release_done = cnt_msb_q & ~dev_vprom_i;

	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			vprom_hld <= 1'b0;
		end else if (ctrl_rst_i || release_done) begin
			vprom_hld <= 1'b0;
		end else begin
			vprom_hld <= dev_vprom_i | vprom_hld;
		end
	end

	// Release counter, held at zero while the device is addressed
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			release_cnt <= '0;
		end else if (ctrl_rst_i || dev_vprom_i || release_done) begin
			release_cnt <= '0;
		end else if (slow2_en_i && vprom_en_o) begin
			release_cnt <= release_cnt + 1'b1;
		end
	end

	// Top bit seen on the slow2 phase
	always_ff @(posedge fastclk or posedge jtimer_clr) begin
		if (jtimer_clr) begin
			cnt_msb_q <= 1'b0;
		end else if (ctrl_rst_i) begin
			cnt_msb_q <= 1'b0;
		end else if (slow2_en_i) begin
			cnt_msb_q <= release_cnt[`DMB_VPROM_CNT_W-1];
		end
	end

endmodule

`default_nettype wire

//--- verilog/vme_bus_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "dmb_config.svh"

module vme_bus_port (
	input  logic               fastclk,
	input  logic               tovme_b_i,
	input  logic               slow_en_i,
	input  logic               cfeb_dtack_i,
	input  dmb_pkg::vme_data_t cfeb_rdata_i,
	output dmb_pkg::vme_data_t outdata_o,
	output logic               dtack_b_o,
	output logic               doe_b_o
);

	logic [`DMB_OE_TIMER_W-1:0] oe_timer;
	logic                       oe_sat;

	//////////////////////////////////////////////////////////////////////
	// Acknowledge and read data merge
	//////////////////////////////////////////////////////////////////////

	// Pulled low by the device 1 acknowledge request
	assign dtack_b_o = ~cfeb_dtack_i;

	// Device 1 drives zero when it is not being read
	assign outdata_o = cfeb_rdata_i;

	//////////////////////////////////////////////////////////////////////
	// Data-buffer OE timer
	//////////////////////////////////////////////////////////////////////

	assign oe_sat = oe_timer[`DMB_OE_TIMER_W-1];

	// Cleared while the board is not driving the bus
	always_ff @(posedge fastclk or posedge tovme_b_i) begin
		if (tovme_b_i) begin
			oe_timer <= '0;
		end else if (slow_en_i && !oe_sat) begin
			oe_timer <= oe_timer + 1'b1;
		end
	end

	// Buffer disabled when idle and again once the timer runs out
	assign doe_b_o = oe_sat | tovme_b_i;

	a_doe_held: assert property (@(posedge fastclk)
		(oe_sat && !tovme_b_i) |=> (doe_b_o || tovme_b_i));

endmodule

`default_nettype wire

//--- verilog/dmb_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module dmb_ctrl_top (
	input  logic                fastclk,
	input  logic                jtimer_clr,
	input  logic                glb_rst_i,
	input  logic                soft_rst_i,
	input  logic                done_trg_i,
	input  logic                strobe_i,
	input  logic                strbce_i,
	input  logic                write_b_i,
	input  logic                dev_cfeb_i,
	input  logic                dev_vprom_i,
	input  logic                tovme_b_i,
	input  logic                tck_i,
	input  logic                tdi_i,
	input  logic                tms_i,
	input  dmb_pkg::vme_cmd_t   command_i,
	input  dmb_pkg::vme_data_t  indata_i,
	input  dmb_pkg::cfeb_mask_t cfeb_tdo_i,
	output dmb_pkg::vme_data_t  outdata_o,
	output logic                dtack_b_o,
	output logic                doe_b_o,
	output logic                init_jtags_o,
	output logic                vprom_en_o,
	output logic                cfeb_tdi_o,
	output logic                cfeb_tms_o,
	output logic                cfeb_tdo_o,
	output dmb_pkg::cfeb_mask_t cfeb_tck_o
);
	import dmb_pkg::*;

	logic      slow_en;
	logic      slow2_en;
	logic      ctrl_rst;
	logic      cfeb_dtack;
	vme_data_t cfeb_rdata;

	//////////////////////////////////////////////////////////////////////
	// Clock phases, reset and JTAG init
	//////////////////////////////////////////////////////////////////////

	// Slow phases drive the init, VPROM and OE timers
	clk_phase_gen clk_phase_gen_inst (
		.fastclk        (fastclk),
		.jtimer_clr     (jtimer_clr),
		.mid_en_o       (),
		.neg_mid_en_o   (),
		.slow_en_o      (slow_en),
		.neg_slow_en_o  (),
		.slow2_en_o     (slow2_en),
		.neg_slow2_en_o ()
	);

	jtag_init_seq jtag_init_seq_inst (
		.fastclk      (fastclk),
		.jtimer_clr   (jtimer_clr),
		.glb_rst_i    (glb_rst_i),
		.soft_rst_i   (soft_rst_i),
		.done_trg_i   (done_trg_i),
		.slow2_en_i   (slow2_en),
		.ctrl_rst_o   (ctrl_rst),
		.init_jtags_o (init_jtags_o)
	);

	//////////////////////////////////////////////////////////////////////
	// Device 1 and device 4
	//////////////////////////////////////////////////////////////////////

	cfeb_sel_regs cfeb_sel_regs_inst (
		.fastclk    (fastclk),
		.jtimer_clr (jtimer_clr),
		.ctrl_rst_i (ctrl_rst),
		.strobe_i   (strobe_i),
		.strbce_i   (strbce_i),
		.write_b_i  (write_b_i),
		.dev_cfeb_i (dev_cfeb_i),
		.command_i  (command_i),
		.indata_i   (indata_i),
		.cfeb_tdo_i (cfeb_tdo_i),
		.tck_i      (tck_i),
		.tdi_i      (tdi_i),
		.tms_i      (tms_i),
		.rdata_o    (cfeb_rdata),
		.dtack_o    (cfeb_dtack),
		.cfeb_tck_o (cfeb_tck_o),
		.cfeb_tdi_o (cfeb_tdi_o),
		.cfeb_tms_o (cfeb_tms_o),
		.cfeb_tdo_o (cfeb_tdo_o)
	);

	vprom_en_ctrl vprom_en_ctrl_inst (
		.fastclk      (fastclk),
		.jtimer_clr   (jtimer_clr),
		.ctrl_rst_i   (ctrl_rst),
		.dev_vprom_i  (dev_vprom_i),
		.init_jtags_i (init_jtags_o),
		.slow2_en_i   (slow2_en),
		.vprom_en_o   (vprom_en_o)
	);

	// VME side
	vme_bus_port vme_bus_port_inst (
		.fastclk      (fastclk),
		.tovme_b_i    (tovme_b_i),
		.slow_en_i    (slow_en),
		.cfeb_dtack_i (cfeb_dtack),
		.cfeb_rdata_i (cfeb_rdata),
		.outdata_o    (outdata_o),
		.dtack_b_o    (dtack_b_o),
		.doe_b_o      (doe_b_o)
	);

endmodule

`default_nettype wire

//--- tests/tb_dmb_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dmb_config.svh"

module tb_dmb_ctrl;
	import dmb_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_CFEB = `DMB_NUM_CFEB;
	localparam int CMD_SEL = `DMB_CMD_CFEB_SEL;
	localparam int CMD_READ = `DMB_CMD_CFEB_READ;
	localparam int SLOW2_CYC = 1 << `DMB_CLKCNT_W;
	localparam int SLOW_CYC = SLOW2_CYC / 2;
	localparam int INIT_HIGH_CYC = 16 * SLOW2_CYC;
	localparam int INIT_WAIT_CYC = 24 * SLOW2_CYC;
	localparam int QUIET_CYC = 8 * SLOW2_CYC;
	localparam int CFEB_ITER = 16;
	localparam int ROUTE_ITER = 16;
	localparam int VPROM_ITER = 3;
	localparam int OE_ITER = 4;
	localparam int VPROM_MAX_CYC = 132 * SLOW2_CYC;
	localparam int OE_MAX_CYC = 132 * SLOW_CYC;
	localparam int TEST_CYC = 2 * (INIT_WAIT_CYC + 2 * INIT_HIGH_CYC + QUIET_CYC + 16)
		+ CFEB_ITER * 16 + ROUTE_ITER * 12
		+ VPROM_ITER * (128 + VPROM_MAX_CYC + 3 * SLOW2_CYC)
		+ OE_ITER * (OE_MAX_CYC + 4 * SLOW_CYC) + 100;
	localparam int WATCHDOG_NS = (TEST_CYC + TEST_CYC / 4) * CLK_PERIOD;

	logic fastclk;
	logic jtimer_clr;
	logic glb_rst_i;
	logic soft_rst_i;
	logic done_trg_i;
	logic strobe_i;
	logic strbce_i;
	logic write_b_i;
	logic dev_cfeb_i;
	logic dev_vprom_i;
	logic tovme_b_i;
	logic tck_i;
	logic tdi_i;
	logic tms_i;
	vme_cmd_t command_i;
	vme_data_t indata_i;
	cfeb_mask_t cfeb_tdo_i;
	vme_data_t outdata_o;
	logic dtack_b_o;
	logic doe_b_o;
	logic init_jtags_o;
	logic vprom_en_o;
	logic cfeb_tdi_o;
	logic cfeb_tms_o;
	logic cfeb_tdo_o;
	cfeb_mask_t cfeb_tck_o;

	logic [31:0] lfsr_state;
	cfeb_mask_t mask_model;
	int errors;
	int checks;
	int test_num;
	int test_checks;
	int test_errors;

	dmb_ctrl_top dmb_ctrl_top_inst (.*);

	initial fastclk = 1'b0;
	always #(CLK_PERIOD / 2) fastclk = ~fastclk;

	//////////////////////////////////////////////////////////////////////
	// Random source and checkers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	// Half one-hot, half arbitrary
	function automatic cfeb_mask_t rand_mask();
		cfeb_mask_t m;
		if (rand_bits(1)) begin
			m = cfeb_mask_t'(1 << (rand_bits(3) % NUM_CFEB));
		end else begin
			m = cfeb_mask_t'(rand_bits(NUM_CFEB));
		end
		return m;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_range(input string name, input int got, input int lo, input int hi);
		checks++;
		assert (got >= lo && got <= hi) else begin
			errors++;
			$display("FAIL t=%0t %s got %0d expected %0d to %0d", $time, name, got, lo, hi);
		end
	endtask

	task automatic end_test(input string name);
		test_num++;
		$display("test %0d %s: %0d checks, %0d errors", test_num, name,
			checks - test_checks, errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	// One strobe on device 1, acknowledge expected in the next cycle only
	task automatic bus_cycle(input vme_cmd_t cmd, input vme_data_t data, input logic wr_b);
		logic ack_exp;
		vme_data_t rd_exp;
		ack_exp = (cmd == CMD_SEL) || (cmd == CMD_READ);
		rd_exp = (wr_b && cmd == CMD_READ) ? vme_data_t'(mask_model) : '0;
		@(posedge fastclk);
		#1;
		dev_cfeb_i = 1'b1;
		command_i = cmd;
		indata_i = data;
		write_b_i = wr_b;
		strobe_i = 1'b1;
		strbce_i = 1'b1;
		@(negedge fastclk);
		check_val("outdata_o", outdata_o, rd_exp);
		check_val("dtack_b_o", dtack_b_o, 1'b1);
		@(posedge fastclk);
		#1;
		if (cmd == CMD_SEL) begin
			mask_model = data[NUM_CFEB-1:0];
		end
		dev_cfeb_i = 1'b0;
		command_i = '0;
		write_b_i = 1'b1;
		strobe_i = 1'b0;
		strbce_i = 1'b0;
		@(negedge fastclk);
		check_val("dtack_b_o", dtack_b_o, !ack_exp);
		check_val("outdata_o", outdata_o, 0);
		@(negedge fastclk);
		check_val("dtack_b_o", dtack_b_o, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic run_reset_values();
		@(negedge fastclk);
		check_val("dtack_b_o", dtack_b_o, 1'b1);
		check_val("doe_b_o", doe_b_o, 1'b1);
		check_val("init_jtags_o", init_jtags_o, 1'b0);
		check_val("vprom_en_o", vprom_en_o, 1'b0);
		check_val("outdata_o", outdata_o, 0);
	endtask

	task automatic run_init_window(input logic use_soft);
		int wait_cyc;
		int high_cyc;
		logic seen;
		wait_cyc = 0;
		high_cyc = 0;
		seen = 1'b0;
		@(posedge fastclk);
		#1;
		if (use_soft) begin
			soft_rst_i = 1'b1;
			done_trg_i = 1'b1;
		end else begin
			glb_rst_i = 1'b1;
		end
		repeat (1 + rand_bits(3)) @(posedge fastclk);
		#1;
		glb_rst_i = 1'b0;
		soft_rst_i = 1'b0;
		done_trg_i = 1'b0;
		while (!seen && wait_cyc < INIT_WAIT_CYC) begin
			@(negedge fastclk);
			if (init_jtags_o) begin
				seen = 1'b1;
			end else begin
				wait_cyc++;
			end
		end
		assert (seen) else begin
			errors++;
			$display("init_jtags_o never rose after the reset request was released");
		end
		if (seen) begin
			while (init_jtags_o && high_cyc < 2 * INIT_HIGH_CYC) begin
				high_cyc++;
				@(negedge fastclk);
			end
			check_val("init_jtags_o high cycles", high_cyc, INIT_HIGH_CYC);
			repeat (QUIET_CYC) begin
				@(negedge fastclk);
				check_val("init_jtags_o", init_jtags_o, 1'b0);
			end
		end
	endtask

	task automatic run_select_rw(input int n);
		vme_data_t data;
		vme_cmd_t bad_cmd;
		for (int i = 0; i < n; i++) begin
			data = vme_data_t'(rand_bits(`DMB_DATA_W));
			data[NUM_CFEB-1:0] = rand_mask();
			bus_cycle(vme_cmd_t'(CMD_SEL), data, 1'b0);
			bus_cycle(vme_cmd_t'(CMD_READ), '0, 1'b1);
			bad_cmd = vme_cmd_t'(rand_bits(`DMB_CMD_W));
			if (bad_cmd == CMD_SEL || bad_cmd == CMD_READ) begin
				bad_cmd[`DMB_CMD_W-1] = 1'b1;
			end
			bus_cycle(bad_cmd, vme_data_t'(rand_bits(`DMB_DATA_W)), rand_bits(1));
			bus_cycle(vme_cmd_t'(CMD_READ), '0, 1'b1);
		end
	endtask

	task automatic run_routing(input int n);
		vme_data_t data;
		logic exp_tdo;
		for (int i = 0; i < n; i++) begin
			data = vme_data_t'(rand_bits(`DMB_DATA_W));
			data[NUM_CFEB-1:0] = rand_mask();
			bus_cycle(vme_cmd_t'(CMD_SEL), data, 1'b0);
			repeat (8) begin
				@(posedge fastclk);
				#1;
				tck_i = rand_bits(1);
				tdi_i = rand_bits(1);
				tms_i = rand_bits(1);
				cfeb_tdo_i = cfeb_mask_t'(rand_bits(NUM_CFEB));
				@(negedge fastclk);
				// TDO only from a single selected board
				exp_tdo = ($countones(mask_model) == 1) ? |(mask_model & cfeb_tdo_i) : 1'b0;
				check_val("cfeb_tck_o", cfeb_tck_o, {NUM_CFEB{tck_i}} & mask_model);
				check_val("cfeb_tdi_o", cfeb_tdi_o, tdi_i);
				check_val("cfeb_tms_o", cfeb_tms_o, tms_i);
				check_val("cfeb_tdo_o", cfeb_tdo_o, exp_tdo);
			end
		end
	endtask

	task automatic run_vprom(input int n);
		int rel_cyc;
		for (int i = 0; i < n; i++) begin
			@(posedge fastclk);
			#1;
			dev_vprom_i = 1'b1;
			repeat (1 + rand_bits(7)) begin
				@(negedge fastclk);
				check_val("vprom_en_o", vprom_en_o, 1'b1);
			end
			@(posedge fastclk);
			#1;
			dev_vprom_i = 1'b0;
			rel_cyc = 0;
			do begin
				@(negedge fastclk);
				rel_cyc++;
			end while (vprom_en_o && rel_cyc < VPROM_MAX_CYC);
			check_range("vprom_en_o release cycles", rel_cyc, 128 * SLOW2_CYC,
				129 * SLOW2_CYC + 2);
			repeat (2 * SLOW2_CYC) begin
				@(negedge fastclk);
				check_val("vprom_en_o", vprom_en_o, 1'b0);
			end
		end
	endtask

	task automatic run_oe_timer(input int n);
		int cyc;
		for (int i = 0; i < n; i++) begin
			@(posedge fastclk);
			#1;
			tovme_b_i = 1'b0;
			@(negedge fastclk);
			check_val("doe_b_o", doe_b_o, 1'b0);
			if (i % 2 == 0) begin
				// Early release well before saturation
				repeat (1 + rand_bits(10)) begin
					@(negedge fastclk);
					check_val("doe_b_o", doe_b_o, 1'b0);
				end
			end else begin
				cyc = 0;
				do begin
					@(negedge fastclk);
					cyc++;
				end while (!doe_b_o && cyc < OE_MAX_CYC);
				check_range("doe_b_o rise cycles", cyc, 127 * SLOW_CYC, 128 * SLOW_CYC);
				repeat (2 * SLOW_CYC) begin
					@(negedge fastclk);
					check_val("doe_b_o", doe_b_o, 1'b1);
				end
			end
			@(posedge fastclk);
			#1;
			tovme_b_i = 1'b1;
			@(negedge fastclk);
			check_val("doe_b_o", doe_b_o, 1'b1);
			repeat (SLOW_CYC) @(negedge fastclk);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		lfsr_state = 32'h472a65ce;
		mask_model = '0;
		errors = 0;
		checks = 0;
		test_num = 0;
		test_checks = 0;
		test_errors = 0;
		jtimer_clr = 1'b1;
		glb_rst_i = 1'b0;
		soft_rst_i = 1'b0;
		done_trg_i = 1'b0;
		strobe_i = 1'b0;
		strbce_i = 1'b0;
		write_b_i = 1'b1;
		dev_cfeb_i = 1'b0;
		dev_vprom_i = 1'b0;
		tovme_b_i = 1'b1;
		tck_i = 1'b0;
		tdi_i = 1'b0;
		tms_i = 1'b0;
		command_i = '0;
		indata_i = '0;
		cfeb_tdo_i = '0;
		repeat (4) @(posedge fastclk);
		#1;
		jtimer_clr = 1'b0;
		run_reset_values();
		end_test("reset values");
		run_init_window(1'b0);
		run_init_window(1'b1);
		end_test("jtag init window");
		run_select_rw(CFEB_ITER);
		end_test("cfeb select write and read");
		run_routing(ROUTE_ITER);
		end_test("cfeb jtag routing");
		run_vprom(VPROM_ITER);
		end_test("vprom enable release");
		run_oe_timer(OE_ITER);
		end_test("output enable timer");
		$display("%0d tests, %0d checks, %0d errors", test_num, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/dmb_pkg.sv
verilog/clk_phase_gen.sv
verilog/jtag_init_seq.sv
verilog/cfeb_sel_regs.sv
verilog/vprom_en_ctrl.sv
verilog/vme_bus_port.sv
verilog/dmb_ctrl_top.sv
tests/tb_dmb_ctrl.sv
